//--- Makefile
# Verilator build, run and lint for the video memory subsystem

VERILATOR ?= verilator
TOP       ?= vram_subsys_tb
RTL_TOP   ?= vram_subsys_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
source/vram_pkg.sv
source/vram.sv
source/vram_arb.sv
source/video_fetch.sv
source/reg_port.sv
source/vram_subsys_top.sv
tests/vram_subsys_asserts.sv
tests/vram_subsys_tb.sv

//--- source/reg_port.sv
// host register port: write/read address, data and increment
// registers, VRAM request towards the arbiter
module reg_port (
    input  logic              clk,
    input  logic              reset_i,

    // host side
    input  logic              host_wr_i,
    input  logic [1:0]        host_reg_i,
    input  vram_pkg::word_t   host_data_i,
    input  vram_pkg::mask_t   host_mask_i,
    output logic              busy_o,
    output vram_pkg::word_t   host_rdata_o,

    // arbiter side
    input  logic              regs_ack_i,
    input  vram_pkg::word_t   vram_data_i,
    output logic              regs_sel_o,
    output logic              regs_wr_o,
    output vram_pkg::mask_t   regs_mask_o,
    output vram_pkg::addr_t   regs_addr_o,
    output vram_pkg::word_t   regs_data_o
);

    vram_pkg::addr_t  waddr;
    vram_pkg::addr_t  raddr;
    vram_pkg::addr_t  incr;
    vram_pkg::addr_t  host_addr;
    logic             strobe;
    logic             done;

    // host value seen as an address
    assign host_addr = host_data_i[vram_pkg::ADDR_W-1:0];

    // strobes are ignored while a request is open
    assign strobe = host_wr_i && !regs_sel_o;
    assign done   = regs_sel_o && regs_ack_i;

    // request and pointer registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_sel_o <= 1'b0;
            waddr      <= '0;
            raddr      <= '0;
            incr       <= vram_pkg::addr_t'(1);
        end else if (done) begin
            regs_sel_o <= 1'b0;
            // advance the pointer used by this access
            if (regs_wr_o) begin
                waddr <= waddr + incr;
            end else begin
                raddr <= raddr + incr;
            end
        end else if (strobe) begin
            case (host_reg_i)
                vram_pkg::REG_WADDR: begin
                    waddr <= host_addr;
                end
                vram_pkg::REG_RADDR: begin
                    raddr      <= host_addr;
                    regs_sel_o <= 1'b1;
                end
                vram_pkg::REG_DATA: begin
                    regs_sel_o <= 1'b1;
                end
                default: begin
                    incr <= host_addr;
                end
            endcase
        end
    end

    // access payload, latched with the strobe
    always_ff @(posedge clk) begin
        if (strobe) begin
            regs_wr_o   <= (host_reg_i == vram_pkg::REG_DATA);
            regs_data_o <= host_data_i;
            regs_mask_o <= host_mask_i;
        end
    end

    // read word arrives with the ack
    always_ff @(posedge clk) begin
        if (done && !regs_wr_o) begin
            host_rdata_o <= vram_data_i;
        end
    end

    assign regs_addr_o = regs_wr_o ? waddr : raddr;

    // busy spans strobe+1 up to ack+1
    assign busy_o = regs_sel_o;

endmodule

//--- source/video_fetch.sv
// video fetch unit: slot timer, frame-buffer word counter,
// pixel word capture and frame-start flag
module video_fetch (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              video_en_i,
    input  vram_pkg::word_t   vram_data_i,

    output logic              vgen_sel_o,
    output vram_pkg::addr_t   vgen_addr_o,
    output vram_pkg::word_t   pix_word_o,
    output logic              pix_valid_o,
    output logic              frame_start_o
);

    vram_pkg::slot_t    slot_cnt;
    vram_pkg::fb_idx_t  word_idx;
    vram_pkg::word_t    word_hold;

    // address of the word being fetched this slot
    assign vgen_addr_o = vram_pkg::FB_BASE + vram_pkg::addr_t'(word_idx);

    // slot timer and frame word counter
    always_ff @(posedge clk) begin
        if (reset_i || !video_en_i) begin
            slot_cnt   <= '0;
            word_idx   <= '0;
            vgen_sel_o <= 1'b0;
        end else begin
            if (slot_cnt == vram_pkg::SLOT_LAST) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + vram_pkg::slot_t'(1);
            end

            // one read per period
            vgen_sel_o <= (slot_cnt == '0);

            // step after each issued read, wrap at frame end
            if (vgen_sel_o) begin
                if (word_idx == vram_pkg::FB_LAST) begin
                    word_idx <= '0;
                end else begin
                    word_idx <= word_idx + vram_pkg::fb_idx_t'(1);
                end
            end
        end
    end

    // valid and frame flag follow the read by one cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_valid_o   <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            pix_valid_o   <= vgen_sel_o;
            frame_start_o <= vgen_sel_o && (word_idx == '0);
        end
    end

    // hold last pixel word between slots
    always_ff @(posedge clk) begin
        if (pix_valid_o) begin
            word_hold <= vram_data_i;
        end
    end

    // fresh data during the valid cycle, held word otherwise
    assign pix_word_o = pix_valid_o ? vram_data_i : word_hold;

endmodule

//--- source/vram.sv
// single-port word memory with per-nibble write enables
// and a registered read port
module vram (
    input  logic              clk,
    input  logic              sel,
    input  logic              wr_en,
    input  vram_pkg::mask_t   wr_mask,
    input  vram_pkg::addr_t   address_in,
    input  vram_pkg::word_t   data_in,
    output vram_pkg::word_t   data_out
);

    vram_pkg::word_t mem [vram_pkg::VRAM_WORDS];

    // masked write, one nibble per mask bit
    always_ff @(posedge clk) begin
        if (sel && wr_en) begin
            for (int n = 0; n < vram_pkg::MASK_W; n++) begin
                if (wr_mask[n]) begin
                    mem[address_in][n*vram_pkg::NIBBLE_W +: vram_pkg::NIBBLE_W] <=
                        data_in[n*vram_pkg::NIBBLE_W +: vram_pkg::NIBBLE_W];
                end
            end
        end
    end

    // read data appears the cycle after select
    always_ff @(posedge clk) begin
        if (sel && !wr_en) begin
            data_out <= mem[address_in];
        end
    end

endmodule

//--- source/vram_arb.sv
// fixed-priority VRAM arbiter: video reads first, host register
// accesses in free cycles, acknowledge aligned with read data
module vram_arb (
    input  logic              clk,

    // video fetch, read only
    input  logic              vgen_sel_i,
    input  vram_pkg::addr_t   vgen_addr_i,

    // host register port
    input  logic              regs_sel_i,
    input  logic              regs_wr_i,
    input  vram_pkg::mask_t   regs_wr_mask_i,
    input  vram_pkg::addr_t   regs_addr_i,
    input  vram_pkg::word_t   regs_data_i,
    output logic              regs_ack_o,

    // read data shared by both users
    output vram_pkg::word_t   vram_data_o
);

    logic              vram_sel;
    logic              vram_wr;
    vram_pkg::mask_t   vram_wr_mask;
    vram_pkg::addr_t   vram_addr;
    vram_pkg::word_t   vram_wdata;
    logic              regs_grant;

    // no second grant while the previous ack is still out
    assign regs_grant = regs_sel_i && !vgen_sel_i && !regs_ack_o;

    always_comb begin
        vram_sel     = 1'b0;
        vram_wr      = 1'b0;
        vram_addr    = regs_addr_i;
        vram_wr_mask = regs_wr_mask_i;
        vram_wdata   = regs_data_i;
        if (vgen_sel_i) begin
            // video never writes
            vram_sel  = 1'b1;
            vram_addr = vgen_addr_i;
        end else if (regs_grant) begin
            vram_sel = 1'b1;
            vram_wr  = regs_wr_i;
        end
    end

    // ack one cycle after grant, together with read data
    always_ff @(posedge clk) begin
        regs_ack_o <= regs_grant;
    end

    vram vram0 (
        .clk        (clk),
        .sel        (vram_sel),
        .wr_en      (vram_wr),
        .wr_mask    (vram_wr_mask),
        .address_in (vram_addr),
        .data_in    (vram_wdata),
        .data_out   (vram_data_o)
    );

endmodule

//--- source/vram_pkg.sv
// shared VRAM types, memory and frame-buffer constants,
// host register numbers
package vram_pkg;

    // memory geometry
    localparam int ADDR_W = 12;
    localparam int DATA_W = 16;
    localparam int MASK_W = 4;
    localparam int NIBBLE_W = DATA_W / MASK_W;
    localparam int VRAM_WORDS = 4096;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [MASK_W-1:0] mask_t;

    // frame buffer: 16 words per line, 4 lines
    localparam addr_t FB_BASE = 12'h100;
    localparam int FB_WORDS = 64;
    localparam int FB_IDX_W = $clog2(FB_WORDS);

    typedef logic [FB_IDX_W-1:0] fb_idx_t;
    localparam fb_idx_t FB_LAST = fb_idx_t'(FB_WORDS - 1);

    // video slot cadence
    localparam int FETCH_PERIOD = 4;
    localparam int SLOT_W = $clog2(FETCH_PERIOD);

    typedef logic [SLOT_W-1:0] slot_t;
    localparam slot_t SLOT_LAST = slot_t'(FETCH_PERIOD - 1);

    // host register numbers
    localparam logic [1:0] REG_WADDR = 2'd0;
    localparam logic [1:0] REG_RADDR = 2'd1;
    localparam logic [1:0] REG_DATA = 2'd2;
    localparam logic [1:0] REG_INCR = 2'd3;

endpackage

//--- source/vram_subsys_top.sv
// video memory subsystem: host register port and video fetch
// sharing one VRAM through the arbiter
module vram_subsys_top (
    input  logic              clk,
    input  logic              reset_i,

    // host port
    input  logic              host_wr_i,
    input  logic [1:0]        host_reg_i,
    input  vram_pkg::word_t   host_data_i,
    input  vram_pkg::mask_t   host_mask_i,
    output logic              busy_o,
    output vram_pkg::word_t   host_rdata_o,

    // video port
    input  logic              video_en_i,
    output vram_pkg::word_t   pix_word_o,
    output logic              pix_valid_o,
    output logic              frame_start_o
);

    logic              regs_sel;
    logic              regs_wr;
    vram_pkg::mask_t   regs_mask;
    vram_pkg::addr_t   regs_addr;
    vram_pkg::word_t   regs_data;
    logic              regs_ack;
    logic              vgen_sel;
    vram_pkg::addr_t   vgen_addr;
    vram_pkg::word_t   vram_data;

    reg_port reg_port0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_wr_i    (host_wr_i),
        .host_reg_i   (host_reg_i),
        .host_data_i  (host_data_i),
        .host_mask_i  (host_mask_i),
        .busy_o       (busy_o),
        .host_rdata_o (host_rdata_o),
        .regs_ack_i   (regs_ack),
        .vram_data_i  (vram_data),
        .regs_sel_o   (regs_sel),
        .regs_wr_o    (regs_wr),
        .regs_mask_o  (regs_mask),
        .regs_addr_o  (regs_addr),
        .regs_data_o  (regs_data)
    );

    video_fetch video_fetch0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .video_en_i    (video_en_i),
        .vram_data_i   (vram_data),
        .vgen_sel_o    (vgen_sel),
        .vgen_addr_o   (vgen_addr),
        .pix_word_o    (pix_word_o),
        .pix_valid_o   (pix_valid_o),
        .frame_start_o (frame_start_o)
    );

    vram_arb vram_arb0 (
        .clk            (clk),
        .vgen_sel_i     (vgen_sel),
        .vgen_addr_i    (vgen_addr),
        .regs_sel_i     (regs_sel),
        .regs_wr_i      (regs_wr),
        .regs_wr_mask_i (regs_mask),
        .regs_addr_i    (regs_addr),
        .regs_data_i    (regs_data),
        .regs_ack_o     (regs_ack),
        .vram_data_o    (vram_data)
    );

endmodule

//--- tests/vram_subsys_asserts.sv
// bound checks on arbiter grant and acknowledge timing
// and on video fetch pixel timing
module vram_subsys_asserts (
    input logic clk,
    input logic reset_i,
    input logic vgen_sel_i,
    input logic regs_ack_i,
    input logic fetch_sel_i,
    input logic pix_valid_i
);

    // acknowledge is a one-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (reset_i)
        regs_ack_i |=> !regs_ack_i
    ) else $error("regs_ack_o high in two consecutive cycles");

    // video owns its cycle outright, so no ack follows it
    no_grant_on_vgen: assert property (
        @(posedge clk) disable iff (reset_i)
        vgen_sel_i |=> !regs_ack_i
    ) else $error("register grant in a video cycle");

    pix_after_sel: assert property (
        @(posedge clk) disable iff (reset_i)
        fetch_sel_i |=> pix_valid_i
    ) else $error("pix_valid_o missing one cycle after vgen_sel_o");

    pix_only_after_sel: assert property (
        @(posedge clk) disable iff (reset_i)
        !fetch_sel_i |=> !pix_valid_i
    ) else $error("pix_valid_o without vgen_sel_o one cycle before");

endmodule

// arbiter has no reset and no pixel side
bind vram_arb vram_subsys_asserts arb_asserts0 (
    .clk          (clk),
    .reset_i      (1'b0),
    .vgen_sel_i   (vgen_sel_i),
    .regs_ack_i   (regs_ack_o),
    .fetch_sel_i  (1'b0),
    .pix_valid_i  (1'b0)
);

bind video_fetch vram_subsys_asserts fetch_asserts0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .vgen_sel_i   (1'b0),
    .regs_ack_i   (1'b0),
    .fetch_sel_i  (vgen_sel_o),
    .pix_valid_i  (pix_valid_o)
);

//--- tests/vram_subsys_tb.sv
// video memory subsystem testbench with testdata-driven host
// operations, VRAM and register model and pixel checker
module vram_subsys_tb;

    localparam int MAX_OPS = 64;

    logic              clk;
    logic              reset_i;
    logic              host_wr_i;
    logic [1:0]        host_reg_i;
    vram_pkg::word_t   host_data_i;
    vram_pkg::mask_t   host_mask_i;
    logic              busy_o;
    vram_pkg::word_t   host_rdata_o;
    logic              video_en_i;
    vram_pkg::word_t   pix_word_o;
    logic              pix_valid_o;
    logic              frame_start_o;

    // operations loaded from the testdata file
    int                op_test [MAX_OPS];
    int                op_kind [MAX_OPS];
    logic [1:0]        op_reg [MAX_OPS];
    vram_pkg::mask_t   op_mask [MAX_OPS];
    vram_pkg::word_t   op_data [MAX_OPS];
    vram_pkg::word_t   op_expect [MAX_OPS];
    int                n_ops = 0;

    // memory model and the set of fully written words
    vram_pkg::word_t   model_mem [vram_pkg::VRAM_WORDS];
    bit                model_known [vram_pkg::VRAM_WORDS];
    vram_pkg::addr_t   model_waddr;
    vram_pkg::addr_t   model_incr;

    // video model
    int                pix_idx = 0;
    bit                en_low_prev = 1'b1;
    vram_pkg::addr_t   pix_addr;
    vram_pkg::word_t   hold_word;
    bit                hold_known = 1'b0;

    int                errors = 0;
    int                test_errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                pixels = 0;
    int                cycles = 0;
    int                cycle_limit = 2000;
    int unsigned       lcg_state = 32'd80370;

    vram_subsys_top dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .host_wr_i     (host_wr_i),
        .host_reg_i    (host_reg_i),
        .host_data_i   (host_data_i),
        .host_mask_i   (host_mask_i),
        .busy_o        (busy_o),
        .host_rdata_o  (host_rdata_o),
        .video_en_i    (video_en_i),
        .pix_word_o    (pix_word_o),
        .pix_valid_o   (pix_valid_o),
        .frame_start_o (frame_start_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // run limit grows with the number of operations
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vram_pkg::word_t merge_nibbles(
        input vram_pkg::word_t old_word,
        input vram_pkg::word_t new_word,
        input vram_pkg::mask_t mask
    );
        vram_pkg::word_t result;
        result = old_word;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
                result[4*n +: 4] = new_word[4*n +: 4];
            end
        end
        return result;
    endfunction

    task automatic report_mismatch(input string name, input vram_pkg::word_t got,
                                   input vram_pkg::word_t expected);
        $display("FAILED %s: got %h, expected %h", name, got, expected);
        errors++;
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("error: %s", what);
        errors++;
        test_errors++;
    endtask

    task automatic end_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d done: ok", num);
        end else begin
            tests_failed++;
            $display("test %0d done: %0d errors", num, test_errors);
        end
        test_errors = 0;
    endtask

    // one strobe, wait for completion, then update the model
    task automatic host_access(input logic [1:0] reg_num, input vram_pkg::mask_t mask,
                               input vram_pkg::word_t data);
        vram_pkg::addr_t value;
        value = data[vram_pkg::ADDR_W-1:0];
        @(posedge clk);
        #1;
        host_wr_i   = 1'b1;
        host_reg_i  = reg_num;
        host_data_i = data;
        host_mask_i = mask;
        @(posedge clk);
        #1;
        host_wr_i = 1'b0;
        if (reg_num == vram_pkg::REG_DATA || reg_num == vram_pkg::REG_RADDR) begin
            if (!busy_o) begin
                report_problem("busy_o did not rise after an access strobe");
            end
            while (busy_o) begin
                @(posedge clk);
                #1;
            end
        end
        case (reg_num)
            vram_pkg::REG_WADDR: begin
                model_waddr = value;
            end
            vram_pkg::REG_DATA: begin
                model_mem[model_waddr] = merge_nibbles(model_mem[model_waddr], data, mask);
                if (mask == 4'hF) begin
                    model_known[model_waddr] = 1'b1;
                end
                model_waddr = model_waddr + model_incr;
            end
            vram_pkg::REG_INCR: begin
                model_incr = value;
            end
            default: begin
            end
        endcase
    endtask

    // pixel checker sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_i) begin
            if (pix_valid_o) begin
                pix_addr = vram_pkg::FB_BASE + vram_pkg::addr_t'(pix_idx);
                if (!model_known[pix_addr]) begin
                    report_problem("pixel fetched from a frame word never written");
                end else if (pix_word_o !== model_mem[pix_addr]) begin
                    report_mismatch("pix_word_o", pix_word_o, model_mem[pix_addr]);
                end
                hold_word  = model_mem[pix_addr];
                hold_known = model_known[pix_addr];
                if (frame_start_o !== (pix_idx == 0)) begin
                    report_mismatch("frame_start_o", vram_pkg::word_t'(frame_start_o),
                                    vram_pkg::word_t'(pix_idx == 0));
                end
                pix_idx = (pix_idx + 1) % vram_pkg::FB_WORDS;
                pixels++;
            end else begin
                if (frame_start_o) begin
                    report_problem("frame_start_o high without a pixel");
                end
                // last pixel word stays on the output between slots
                if (hold_known && pix_word_o !== hold_word) begin
                    report_mismatch("pix_word_o", pix_word_o, hold_word);
                    hold_known = 1'b0;
                end
            end
            // a slot in flight still delivers one pixel after disable
            if (!video_en_i && en_low_prev) begin
                pix_idx = 0;
            end
            en_low_prev = !video_en_i;
        end
    end

    initial begin
        int fd;
        string line;
        int t;
        int k;
        int r;
        int m;
        int d;
        int e;
        int gap;
        int cur_test;
        vram_pkg::addr_t rd_addr;

        reset_i     = 1'b1;
        host_wr_i   = 1'b0;
        host_reg_i  = 2'd0;
        host_data_i = '0;
        host_mask_i = '0;
        video_en_i  = 1'b0;
        model_waddr = '0;
        model_incr  = vram_pkg::addr_t'(1);

        fd = $fopen("tests/vram_subsys_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open tests/vram_subsys_testdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "%d %d %h %h %h %h", t, k, r, m, d, e) == 6
                    && n_ops < MAX_OPS) begin
                    op_test[n_ops]   = t;
                    op_kind[n_ops]   = k;
                    op_reg[n_ops]    = r[1:0];
                    op_mask[n_ops]   = m[3:0];
                    op_data[n_ops]   = d[15:0];
                    op_expect[n_ops] = e[15:0];
                    n_ops++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_ops * 16 + 2000;

        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        if (busy_o !== 1'b0) begin
            report_mismatch("busy_o", vram_pkg::word_t'(busy_o), '0);
        end
        if (pix_valid_o !== 1'b0) begin
            report_mismatch("pix_valid_o", vram_pkg::word_t'(pix_valid_o), '0);
        end
        if (frame_start_o !== 1'b0) begin
            report_mismatch("frame_start_o", vram_pkg::word_t'(frame_start_o), '0);
        end

        cur_test = (n_ops > 0) ? op_test[0] : 0;
        for (int i = 0; i < n_ops; i++) begin
            if (op_test[i] != cur_test) begin
                end_test(cur_test);
                cur_test = op_test[i];
            end
            gap = int'((next_random() >> 16) % 4);
            repeat (gap) @(posedge clk);
            case (op_kind[i])
                0: begin
                    host_access(op_reg[i], op_mask[i], op_data[i]);
                end
                1: begin
                    rd_addr = op_data[i][vram_pkg::ADDR_W-1:0];
                    host_access(vram_pkg::REG_RADDR, op_mask[i], op_data[i]);
                    if (!model_known[rd_addr]) begin
                        report_problem("host read of a word never fully written");
                    end else if (host_rdata_o !== model_mem[rd_addr]) begin
                        report_mismatch("host_rdata_o", host_rdata_o, model_mem[rd_addr]);
                    end
                    if (host_rdata_o !== op_expect[i]) begin
                        report_mismatch("host_rdata_o", host_rdata_o, op_expect[i]);
                    end
                end
                2: begin
                    @(posedge clk);
                    #1;
                    video_en_i = op_data[i][0];
                end
                3: begin
                    repeat (int'(op_data[i])) @(posedge clk);
                end
                4: begin
                    // fill words mix a random value with the full address
                    for (int j = 0; j < int'(op_data[i]); j++) begin
                        host_access(vram_pkg::REG_DATA, 4'hF,
                                    vram_pkg::word_t'(next_random() >> 8)
                                    ^ vram_pkg::word_t'(model_waddr));
                    end
                end
                default: begin
                    report_problem("unknown operation kind in the testdata");
                end
            endcase
        end
        end_test(cur_test);

        if (pixels == 0) begin
            report_problem("no pixel words were checked");
        end
        $display("tests run %0d, tests failed %0d, pixels checked %0d, errors %0d",
                 tests_run, tests_failed, pixels, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/vram_subsys_testdata.txt
# columns: test kind reg mask data expect (reg, mask, data, expect in hex)
# kind: 0 host write, 1 read and check, 2 video enable, 3 idle cycles, 4 frame fill
1 0 0 F 0000 0000
1 0 2 F A5C3 0000
1 1 1 F 0000 A5C3
2 0 0 F 0040 0000
2 0 2 F 1234 0000
2 0 2 F BEEF 0000
2 1 1 F 0041 BEEF
2 1 1 F 0040 1234
3 0 0 F 0050 0000
3 0 2 F 1111 0000
3 0 2 F 2222 0000
3 0 0 F 0050 0000
3 0 2 5 ABCD 0000
3 0 2 A 7777 0000
3 1 1 F 0050 1B1D
3 1 1 F 0051 7272
3 0 0 F 0051 0000
3 0 2 0 FFFF 0000
3 1 1 F 0051 7272
4 0 3 F 0003 0000
4 0 0 F 0200 0000
4 0 2 F C001 0000
4 0 2 F C002 0000
4 0 2 F C003 0000
4 1 1 F 0206 C003
4 1 1 F 0203 C002
4 1 1 F 0200 C001
4 0 3 F 0001 0000
5 0 0 F 0100 0000
5 4 2 F 0040 0000
5 2 0 0 0001 0000
5 3 0 0 0200 0000
5 2 0 0 0000 0000
5 3 0 0 0008 0000
6 2 0 0 0001 0000
6 0 0 F 0104 0000
6 0 2 F 5A5A 0000
6 0 2 F 0000 0000
6 0 0 F 0105 0000
6 0 2 3 00C3 0000
6 1 1 F 0104 5A5A
6 1 1 F 0105 00C3
6 3 0 0 0100 0000
6 2 0 0 0000 0000
